// ==== Bender.yml ====
package:
  name: dm_cache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/cache_types_pkg.sv
      - rtl/mem_bus_pkg.sv
      - rtl/tag_store.sv
      - rtl/data_store.sv
      - rtl/refill_port.sv
      - rtl/cache_ctrl.sv
      - rtl/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/mem_responder.sv
      - test/tb_cache_top.sv

// ==== include/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Total data capacity in bytes.
`define CACHE_SIZE_BYTES 8192

// Width of one cache line and of the memory data bus.
`define LINE_BITS 128

// Processor byte address width.
`define ADDR_BITS 32

// Processor data word width.
`define WORD_BITS 32

// Number of lines in the direct-mapped array.
`define NUM_LINES (`CACHE_SIZE_BYTES * 8 / `LINE_BITS)

// Number of processor words in one line.
`define WORDS_PER_LINE (`LINE_BITS / `WORD_BITS)

`endif

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cpu_req,
    input  wire cache_types_pkg::addr_t  cpu_addr,
    output logic                         cpu_ack,
    output logic                         cpu_hit,
    output cache_types_pkg::addr_t       lookup_addr,
    input  wire                          hit,
    output logic                         rd_en,
    output logic                         fill_en,
    output logic                         refill_start,
    input  wire                          refill_done
);

    cache_types_pkg::ctrl_state_t state;

    // A hit reads straight from the array; a fill reads through the bypass.
    assign rd_en   = ((state == cache_types_pkg::LOOKUP) && hit) ||
                     (state == cache_types_pkg::FILL);
    assign fill_en = (state == cache_types_pkg::FILL);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= cache_types_pkg::IDLE;
            cpu_ack      <= 1'b0;
            cpu_hit      <= 1'b0;
            refill_start <= 1'b0;
        end else begin
            refill_start <= 1'b0;
            case (state)
                cache_types_pkg::IDLE: begin
                    if (cpu_req) begin
                        state <= cache_types_pkg::LOOKUP;
                    end
                end
                cache_types_pkg::LOOKUP: begin
                    cpu_hit <= hit;
                    if (hit) begin
                        state <= cache_types_pkg::RESPOND;
                    end else begin
                        refill_start <= 1'b1; // High for the first REFILL cycle only.
                        state        <= cache_types_pkg::REFILL;
                    end
                end
                cache_types_pkg::REFILL: begin
                    if (refill_done) begin
                        state <= cache_types_pkg::FILL;
                    end
                end
                cache_types_pkg::FILL: begin
                    state <= cache_types_pkg::RESPOND;
                end
                cache_types_pkg::RESPOND: begin
                    cpu_ack <= 1'b1;
                    // Wait here for the processor to release its request.
                    if (cpu_ack && !cpu_req) begin
                        state <= cache_types_pkg::RELEASE;
                    end
                end
                cache_types_pkg::RELEASE: begin
                    cpu_ack <= 1'b0;
                    cpu_hit <= 1'b0;
                    state   <= cache_types_pkg::IDLE;
                end
                default: begin
                    state <= cache_types_pkg::IDLE;
                end
            endcase
        end
    end

    // The address is held for the whole request, which keeps both stores pointed at one line.
    always_ff @(posedge clk) begin
        if (state == cache_types_pkg::IDLE && cpu_req) begin
            lookup_addr <= cpu_addr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cpu_req,
    input  wire cache_types_pkg::addr_t  cpu_addr,
    output logic                         cpu_ack,
    output cache_types_pkg::word_t       cpu_data,
    output logic                         cpu_hit,
    output logic                         mem_req,
    output mem_bus_pkg::line_addr_t      mem_addr,
    input  wire                          mem_ack,
    input  wire mem_bus_pkg::mem_line_t  mem_data
);

    cache_types_pkg::addr_t lookup_addr;
    cache_types_pkg::line_t refill_line;

    logic hit;
    logic rd_en;
    logic fill_en;
    logic refill_start;
    logic refill_done;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .cpu_ack      (cpu_ack),
        .cpu_hit      (cpu_hit),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .rd_en        (rd_en),
        .fill_en      (fill_en),
        .refill_start (refill_start),
        .refill_done  (refill_done)
    );

    tag_store u_tags (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .hit         (hit)
    );

    data_store u_data (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_line   (refill_line),
        .rd_en       (rd_en),
        .rd_word     (cpu_data)
    );

    refill_port u_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .lookup_addr  (lookup_addr),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_data     (mem_data),
        .refill_line  (refill_line),
        .refill_done  (refill_done)
    );

endmodule

`default_nettype wire

// ==== rtl/cache_types_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package cache_types_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [`WORD_BITS-1:0] word_t;
    typedef logic [`LINE_BITS-1:0] line_t;

    // From low to high the address holds byte in word, word in line, line index and tag.
    typedef logic [$clog2(`NUM_LINES)-1:0]      index_t;
    typedef logic [$clog2(`WORDS_PER_LINE)-1:0] offset_t;
    typedef logic [`ADDR_BITS - $clog2(`NUM_LINES) - $clog2(`LINE_BITS / 8) - 1:0] tag_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        FILL,
        RESPOND,
        RELEASE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/data_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module data_store (
    input  wire                          clk,
    input  wire                          rst,
    input  wire cache_types_pkg::addr_t  lookup_addr,
    input  wire                          fill_en,
    input  wire cache_types_pkg::line_t  fill_line,
    input  wire                          rd_en,
    output cache_types_pkg::word_t       rd_word
);

    localparam int OFF_LSB = $clog2(`WORD_BITS / 8);
    localparam int IDX_LSB = $clog2(`LINE_BITS / 8);

    cache_types_pkg::index_t  idx;
    cache_types_pkg::offset_t off;
    cache_types_pkg::line_t   src_line;
    cache_types_pkg::word_t   sel_word;

    cache_types_pkg::line_t   lines [`NUM_LINES];

    assign idx = lookup_addr[IDX_LSB +: $bits(cache_types_pkg::index_t)];
    assign off = lookup_addr[OFF_LSB +: $bits(cache_types_pkg::offset_t)];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[idx] <= fill_line;
        end
    end

    // During a fill the array still holds the old line, so read the incoming one.
    assign src_line = fill_en ? fill_line : lines[idx];
    assign sel_word = src_line[off * `WORD_BITS +: `WORD_BITS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_word <= '0;
        end else if (rd_en) begin
            rd_word <= sel_word; // Held until the next read, so cpu_data stays stable.
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_bus_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package mem_bus_pkg;

    // Memory is addressed in whole lines, so the byte-in-line bits are dropped.
    typedef logic [`ADDR_BITS - $clog2(`LINE_BITS / 8) - 1:0] line_addr_t;
    typedef logic [`LINE_BITS-1:0] mem_line_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_DROP,
        R_DONE
    } refill_state_t;

endpackage

`default_nettype wire

// ==== rtl/refill_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module refill_port (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          refill_start,
    input  wire cache_types_pkg::addr_t  lookup_addr,
    output logic                         mem_req,
    output mem_bus_pkg::line_addr_t      mem_addr,
    input  wire                          mem_ack,
    input  wire mem_bus_pkg::mem_line_t  mem_data,
    output cache_types_pkg::line_t       refill_line,
    output logic                         refill_done
);

    mem_bus_pkg::refill_state_t state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= mem_bus_pkg::R_IDLE;
            mem_req     <= 1'b0;
            refill_done <= 1'b0;
        end else begin
            case (state)
                mem_bus_pkg::R_IDLE: begin
                    if (refill_start) begin
                        mem_req <= 1'b1;
                        state   <= mem_bus_pkg::R_REQ;
                    end
                end
                mem_bus_pkg::R_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0; // Line is captured on this same edge.
                        state   <= mem_bus_pkg::R_DROP;
                    end
                end
                mem_bus_pkg::R_DROP: begin
                    // Finish the four-phase cycle before telling the controller.
                    if (!mem_ack) begin
                        refill_done <= 1'b1;
                        state       <= mem_bus_pkg::R_DONE;
                    end
                end
                mem_bus_pkg::R_DONE: begin
                    refill_done <= 1'b0;
                    state       <= mem_bus_pkg::R_IDLE;
                end
                default: begin
                    state <= mem_bus_pkg::R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_bus_pkg::R_IDLE && refill_start) begin
            mem_addr <= lookup_addr[`ADDR_BITS-1 -: $bits(mem_bus_pkg::line_addr_t)];
        end
        if (state == mem_bus_pkg::R_REQ && mem_ack) begin
            refill_line <= mem_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module tag_store (
    input  wire                          clk,
    input  wire                          rst,
    input  wire cache_types_pkg::addr_t  lookup_addr,
    input  wire                          fill_en,
    output logic                         hit
);

    localparam int IDX_LSB = $clog2(`LINE_BITS / 8);
    localparam int TAG_LSB = IDX_LSB + $bits(cache_types_pkg::index_t);

    cache_types_pkg::index_t idx;
    cache_types_pkg::tag_t   tag;

    logic [`NUM_LINES-1:0]  valid;
    cache_types_pkg::tag_t  tags [`NUM_LINES];

    assign idx = lookup_addr[IDX_LSB +: $bits(cache_types_pkg::index_t)];
    assign tag = lookup_addr[TAG_LSB +: $bits(cache_types_pkg::tag_t)];

    // Reset invalidates every line.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[idx] <= tag;
        end
    end

    assign hit = valid[idx] && (tags[idx] == tag); // Stale tags are masked by valid.

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/cache_types_pkg.sv
rtl/mem_bus_pkg.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/refill_port.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
test/mem_responder.sv
test/tb_cache_top.sv

// ==== test/mem_responder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module mem_responder (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           mem_req,
    input  wire mem_bus_pkg::line_addr_t  mem_addr,
    output logic                          mem_ack,
    output mem_bus_pkg::mem_line_t        mem_data
);

    int unsigned delay;

    // Each word holds its own byte address with a marker in the upper half.
    function automatic mem_bus_pkg::mem_line_t line_contents(
        input mem_bus_pkg::line_addr_t line_addr
    );
        mem_bus_pkg::mem_line_t line;
        logic [`ADDR_BITS-1:0]  byte_addr;
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            byte_addr = {line_addr, 4'b0000} + 4 * w;
            line[w * `WORD_BITS +: `WORD_BITS] = byte_addr ^ 32'hc0de_0000;
        end
        return line;
    endfunction

    initial begin
        mem_ack  = 1'b0;
        mem_data = '0;
        forever begin
            @(posedge clk);
            if (rst && mem_req && !mem_ack) begin
                delay = $urandom_range(8, 1);
                repeat (delay - 1) @(posedge clk);
                mem_data <= line_contents(mem_addr);
                mem_ack  <= 1'b1;
                do @(posedge clk); while (mem_req); // Ack stays up until the request drops.
                mem_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module tb_cache_top;

    localparam int DIRECTED_REQS = 9;
    localparam int RANDOM_REQS   = 40;
    localparam int NUM_REQS      = DIRECTED_REQS + RANDOM_REQS;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     cpu_req;
    cache_types_pkg::addr_t   cpu_addr;
    logic                     cpu_ack;
    cache_types_pkg::word_t   cpu_data;
    logic                     cpu_hit;
    logic                     mem_req;
    mem_bus_pkg::line_addr_t  mem_addr;
    logic                     mem_ack;
    mem_bus_pkg::mem_line_t   mem_data;

    logic [`NUM_LINES-1:0]    ref_valid; // Reference copy of the direct-mapped tag array.
    cache_types_pkg::tag_t    ref_tag [`NUM_LINES];
    logic                     exp_hit;
    cache_types_pkg::word_t   exp_data;
    mem_bus_pkg::line_addr_t  exp_line;
    logic                     cpu_req_q = 1'b0;
    logic                     mem_req_q = 1'b0;
    int                       mem_pulses = 0;

    always #5 clk = ~clk;

    cache_top uut (
        .clk (clk), .rst (rst),
        .cpu_req (cpu_req), .cpu_addr (cpu_addr), .cpu_ack (cpu_ack),
        .cpu_data (cpu_data), .cpu_hit (cpu_hit),
        .mem_req (mem_req), .mem_addr (mem_addr), .mem_ack (mem_ack), .mem_data (mem_data)
    );

    mem_responder u_mem (
        .clk (clk), .rst (rst),
        .mem_req (mem_req), .mem_addr (mem_addr), .mem_ack (mem_ack), .mem_data (mem_data)
    );

    function automatic cache_types_pkg::word_t word_at(input cache_types_pkg::addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'hc0de_0000;
    endfunction

    function automatic cache_types_pkg::addr_t pool_addr(input int unsigned sel);
        case (sel)
            0: return 32'h0000_0050;
            1: return 32'h0000_2050; // Same index as entry 0 with the next tag.
            2: return 32'h0000_4050;
            default: return 32'h1234_5670;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("FAIL @ %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    // Runs one four-phase read and keeps the request up for hold extra cycles after the ack.
    task automatic cpu_read(input cache_types_pkg::addr_t addr, input int unsigned hold);
        cache_types_pkg::index_t idx;
        cache_types_pkg::tag_t   tag;
        idx = addr[12:4];
        tag = addr[31:13];
        @(posedge clk);
        exp_hit  <= ref_valid[idx] && (ref_tag[idx] == tag);
        exp_data <= word_at(addr);
        exp_line <= addr[31:4];
        cpu_addr <= addr;
        cpu_req  <= 1'b1;
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
        do @(posedge clk); while (!cpu_ack);
        repeat (hold) @(posedge clk);
        cpu_req <= 1'b0;
        do @(posedge clk); while (cpu_ack);
    endtask

    always @(posedge clk) begin
        cpu_req_q <= cpu_req;
        mem_req_q <= mem_req;
        if (cpu_req && !cpu_req_q) begin
            mem_pulses <= 0;
        end else if (mem_req && !mem_req_q) begin
            mem_pulses <= mem_pulses + 1;
        end
    end

    assert property (@(posedge clk) $rose(rst) |-> !cpu_ack && !mem_req)
        else report_failure("cpu_ack or mem_req high after reset");
    assert property (@(posedge clk) disable iff (!rst) $rose(cpu_ack) |-> cpu_data == exp_data)
        else report_failure("wrong cpu_data");
    assert property (@(posedge clk) disable iff (!rst) $rose(cpu_ack) |-> cpu_hit == exp_hit)
        else report_failure("cpu_hit differs from reference model");
    assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_ack) |-> mem_pulses == (exp_hit ? 0 : 1))
        else report_failure("wrong number of mem_req pulses for request");
    assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_req) && exp_hit |-> ##2 !cpu_ack ##1 cpu_ack)
        else report_failure("hit not acked exactly 2 edges after request");
    assert property (@(posedge clk) disable iff (!rst) cpu_req && exp_hit |-> !mem_req)
        else report_failure("mem_req raised on a hit");
    assert property (@(posedge clk) disable iff (!rst) $rose(mem_req) |-> mem_addr == exp_line)
        else report_failure("wrong mem_addr");
    assert property (@(posedge clk) disable iff (!rst) $rose(cpu_ack) |-> cpu_req)
        else report_failure("cpu_ack rose without cpu_req");
    assert property (@(posedge clk) disable iff (!rst) cpu_ack && cpu_req |=> cpu_ack)
        else report_failure("cpu_ack dropped while cpu_req high");
    assert property (@(posedge clk) disable iff (!rst) $fell(cpu_req) && cpu_ack |-> ##2 !cpu_ack)
        else report_failure("cpu_ack did not fall after cpu_req");
    assert property (@(posedge clk) disable iff (!rst)
        cpu_ack && $past(cpu_ack) |-> $stable(cpu_data))
        else report_failure("cpu_data changed during ack");
    assert property (@(posedge clk) disable iff (!rst) mem_req && !mem_ack |=> mem_req)
        else report_failure("mem_req dropped before mem_ack");
    assert property (@(posedge clk) disable iff (!rst) $rose(mem_req) |-> !mem_ack)
        else report_failure("mem_req rose while mem_ack high");

    initial begin
        void'($urandom(32'h4f18));
        rst       = 1'b0;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        exp_hit   = 1'b0;
        exp_data  = '0;
        exp_line  = '0;
        ref_valid = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        cpu_read(pool_addr(0), 0);
        cpu_read(pool_addr(0) + 4, 2);
        cpu_read(pool_addr(0) + 8, 0);
        cpu_read(pool_addr(0) + 12, 1);
        cpu_read(pool_addr(1) + 4, 0); // Evicts the first line.
        cpu_read(pool_addr(0), 3);
        cpu_read(pool_addr(1) + 8, 0);
        cpu_read(32'hffff_fffc, 1);
        cpu_read(32'hffff_fff0, 0);
        for (int i = 0; i < RANDOM_REQS; i++) begin
            cpu_read(pool_addr($urandom_range(3, 0)) + 4 * $urandom_range(3, 0),
                     $urandom_range(3, 0));
        end
        repeat (4) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

    initial begin
        repeat (NUM_REQS * 40 + 100) @(posedge clk);
        $display("Timeout: requests did not complete within %0d cycles", NUM_REQS * 40 + 100);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
